// File: include/ex_defs.svh
// Sizing macros for the execute stage
// Operator code widths must agree with the enums in ex_pkg
// The ALU shifter takes log2(EX_XLEN) bits, so keep EX_XLEN a power of two
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Data word
`define EX_XLEN 32
// Register address, wide enough for the integer and FP register files
`define EX_REG_AW 6

// Operator code widths
`define EX_ALU_OP_W 4
`define EX_MULT_OP_W 2

// Extra cycles on top of the summed test lengths before the run is stopped
`define EX_TIMEOUT_SLACK 50

`endif

// File: rtl/ex_pkg.sv
// Shared types of the execute stage
// Enum encodings are sequential from zero and fill the full code space
// Struct layouts are fixed by the widths in ex_defs.svh
`include "ex_defs.svh"

package ex_pkg;

  ////////////////////////////////////////
  // Operator codes
  ////////////////////////////////////////

  // Arithmetic and logic group first, branch compares after
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Low word, then the three high-word variants
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MULT_MUL,
    MULT_MULH,
    MULT_MULHSU,
    MULT_MULHU
  } mult_op_e;

  ////////////////////////////////////////
  // Request and write-port bundles
  ////////////////////////////////////////

  // Operand C carries the jump target
  typedef struct packed {
    logic                enable;
    alu_op_e             op;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
    logic [`EX_XLEN-1:0] operand_c;
  } alu_req_t;

  typedef struct packed {
    logic                enable;
    mult_op_e            op;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
  } mult_req_t;

  // Same layout for the forwarding port and the load port
  typedef struct packed {
    logic                  we;
    logic [`EX_REG_AW-1:0] waddr;
    logic [`EX_XLEN-1:0]   wdata;
  } wr_port_t;

endpackage

// File: rtl/ex_alu.sv
// Integer ALU and branch comparator, fully combinational
// Result reads 0 while the request is not enabled
// The shift amount is the low log2(EX_XLEN) bits of operand B
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_alu (
  input  ex_pkg::alu_req_t    req_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);

  import ex_pkg::*;

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic                is_signed;
  logic                do_sub;
  logic [`EX_XLEN:0]   adder_a;
  logic [`EX_XLEN:0]   adder_b;
  logic [`EX_XLEN:0]   adder_sum;
  logic                adder_zero;
  logic                adder_neg;
  logic [SHAMT_W-1:0]  shamt;
  logic [`EX_XLEN-1:0] sra_result;

  ////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////

  // Signed compares extend by the sign bit
  assign is_signed = (req_i.op == ALU_SLT) || (req_i.op == ALU_LT) || (req_i.op == ALU_GE);
  // Only ADD adds, SUB and every compare subtract
  assign do_sub = (req_i.op != ALU_ADD);

  // One extra bit so the top bit of a-b is the true less-than
  assign adder_a = {is_signed & req_i.operand_a[`EX_XLEN-1], req_i.operand_a};
  assign adder_b = {is_signed & req_i.operand_b[`EX_XLEN-1], req_i.operand_b}
                   ^ {(`EX_XLEN+1){do_sub}};
  // Carry in completes the two's complement
  assign adder_sum = adder_a + adder_b + {{`EX_XLEN{1'b0}}, do_sub};

  assign adder_zero = (adder_sum[`EX_XLEN-1:0] == '0);
  assign adder_neg  = adder_sum[`EX_XLEN];

  ////////////////////////////////////////
  // Shifter and result select
  ////////////////////////////////////////

  assign shamt      = req_i.operand_b[SHAMT_W-1:0];
  assign sra_result = $signed(req_i.operand_a) >>> shamt;

  always_comb begin
    result_o = '0;
    if (req_i.enable) begin
      case (req_i.op)
        ALU_ADD,
        ALU_SUB:  result_o = adder_sum[`EX_XLEN-1:0];
        ALU_AND:  result_o = req_i.operand_a & req_i.operand_b;
        ALU_OR:   result_o = req_i.operand_a | req_i.operand_b;
        ALU_XOR:  result_o = req_i.operand_a ^ req_i.operand_b;
        ALU_SLL:  result_o = req_i.operand_a << shamt;
        ALU_SRL:  result_o = req_i.operand_a >> shamt;
        ALU_SRA:  result_o = sra_result;
        ALU_SLT,
        ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, adder_neg};
        // Compares produce no register result
        default:  result_o = '0;
      endcase
    end
  end

  // Branch outcome from the adder flags
  always_comb begin
    case (req_i.op)
      ALU_EQ:          cmp_result_o = adder_zero;
      ALU_NE:          cmp_result_o = ~adder_zero;
      ALU_LT, ALU_LTU: cmp_result_o = adder_neg;
      ALU_GE, ALU_GEU: cmp_result_o = ~adder_neg;
      default:         cmp_result_o = 1'b0;
    endcase
  end

endmodule

// File: rtl/ex_mult.sv
// Integer multiplier with one shared product
// MUL returns the low word in the same cycle with ready held high
// High-word ops take two cycles and hold in the second one until ex_ready_i
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::mult_req_t   req_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                multicycle_o
);

  import ex_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_FINISH
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic                  sign_a;
  logic                  sign_b;
  logic                  high_op;
  logic [2*`EX_XLEN-1:0] op_a_ext;
  logic [2*`EX_XLEN-1:0] op_b_ext;
  logic [2*`EX_XLEN-1:0] prod_full;
  logic [`EX_XLEN-1:0]   prod_hi_q;

  // Operand signedness per op
  assign sign_a = (req_i.op == MULT_MULH) || (req_i.op == MULT_MULHSU);
  assign sign_b = (req_i.op == MULT_MULH);
  assign high_op = req_i.enable && (req_i.op != MULT_MUL);

  // Full-width extension makes a plain product correct for every mode
  assign op_a_ext  = {{`EX_XLEN{sign_a & req_i.operand_a[`EX_XLEN-1]}}, req_i.operand_a};
  assign op_b_ext  = {{`EX_XLEN{sign_b & req_i.operand_b[`EX_XLEN-1]}}, req_i.operand_b};
  assign prod_full = op_a_ext * op_b_ext;

  ////////////////////////////////////////
  // Two-state FSM
  ////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // First cycle of a high-word op stalls the stage
        if (high_op) begin
          ready_o      = 1'b0;
          multicycle_o = 1'b1;
          state_d      = ST_FINISH;
        end
      end
      ST_FINISH: begin
        if (ex_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper half captured once, kept through any stall in ST_FINISH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_hi_q <= '0;
    end else if (state_q == ST_IDLE && high_op) begin
      prod_hi_q <= prod_full[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  assign result_o = (state_q == ST_FINISH) ? prod_hi_q : prod_full[`EX_XLEN-1:0];

endmodule

// File: rtl/ex_fw_mux.sv
// Forwarding write port toward the register file and ID operand muxes
// Enable and address pass straight through from the ID request
// Data priority is CSR, then multiplier, then ALU
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_fw_mux (
  input  logic                  alu_we_i,
  input  logic [`EX_REG_AW-1:0] alu_waddr_i,
  input  logic                  alu_en_i,
  input  logic [`EX_XLEN-1:0]   alu_result_i,
  input  logic                  mult_en_i,
  input  logic [`EX_XLEN-1:0]   mult_result_i,
  input  logic                  csr_access_i,
  input  logic [`EX_XLEN-1:0]   csr_rdata_i,
  output ex_pkg::wr_port_t      fw_o
);

  always_comb begin
    fw_o.we    = alu_we_i;
    fw_o.waddr = alu_waddr_i;
    // Highest priority source first
    if (csr_access_i) begin
      fw_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_o.wdata = alu_result_i;
    end else begin
      // No unit active in EX
      fw_o.wdata = '0;
    end
  end

endmodule

// File: rtl/ex_wb_port.sv
// EX/WB pipeline register, load write port and stage stall control
// Load data comes straight from the LSU, only enable and address are piped
// A branch in EX can leave the stage even while WB is busy
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_wb_port (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  regfile_we_i,
  input  logic [`EX_REG_AW-1:0] regfile_waddr_i,
  input  logic [`EX_XLEN-1:0]   lsu_rdata_i,
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,
  input  logic                  lsu_en_i,
  input  logic                  mult_ready_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  wb_ready_i,
  input  logic                  branch_in_ex_i,
  output ex_pkg::wr_port_t      wb_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic                  units_done;
  logic                  any_en;
  logic                  we_q;
  logic [`EX_REG_AW-1:0] waddr_q;

  ////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////

  // Every unit in EX finished and WB can take a result
  assign units_done = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en     = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Valid does not look at ready since branches resolve without WB
  assign ex_ready_o = units_done | branch_in_ex_i;
  assign ex_valid_o = any_en & units_done;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (ex_valid_o) begin
      we_q <= regfile_we_i;
      // Address only moves for a real write
      if (regfile_we_i) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB free but nothing new, so drop the old write
      we_q <= 1'b0;
    end
  end

  assign wb_o.we    = we_q;
  assign wb_o.waddr = waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

// File: rtl/ex_stage.sv
// Execute stage top with ALU, multiplier and both register write ports
// All outputs are plain levels, there is no handshake on any port
// jump_target_o is operand C of the ALU request, unchanged
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  // From ID
  input  ex_pkg::alu_req_t      alu_req_i,
  input  ex_pkg::mult_req_t     mult_req_i,
  input  logic                  csr_access_i,
  input  logic [`EX_XLEN-1:0]   csr_rdata_i,
  input  logic                  regfile_alu_we_i,
  input  logic [`EX_REG_AW-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [`EX_REG_AW-1:0] regfile_waddr_i,
  // From LSU
  input  logic                  lsu_en_i,
  input  logic [`EX_XLEN-1:0]   lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  // Stall inputs
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  // Write ports, branch outputs and stall outputs
  output ex_pkg::wr_port_t      fw_o,
  output ex_pkg::wr_port_t      wb_o,
  output logic [`EX_XLEN-1:0]   jump_target_o,
  output logic                  branch_decision_o,
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  ////////////////////////////////////////
  // Compute units
  ////////////////////////////////////////

  ex_alu u_alu (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Stage ready closes the multiplier's second cycle
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////

  ex_fw_mux u_fw_mux (
    .alu_we_i      (regfile_alu_we_i),
    .alu_waddr_i   (regfile_alu_waddr_i),
    .alu_en_i      (alu_req_i.enable),
    .alu_result_i  (alu_result),
    .mult_en_i     (mult_req_i.enable),
    .mult_result_i (mult_result),
    .csr_access_i  (csr_access_i),
    .csr_rdata_i   (csr_rdata_i),
    .fw_o          (fw_o)
  );

  ex_wb_port u_wb_port (
    .clk             (clk),
    .rst_n           (rst_n),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .alu_en_i        (alu_req_i.enable),
    .mult_en_i       (mult_req_i.enable),
    .csr_access_i    (csr_access_i),
    .lsu_en_i        (lsu_en_i),
    .mult_ready_i    (mult_ready),
    .lsu_ready_ex_i  (lsu_ready_ex_i),
    .wb_ready_i      (wb_ready_i),
    .branch_in_ex_i  (branch_in_ex_i),
    .wb_o            (wb_o),
    .ex_ready_o      (ex_ready_o),
    .ex_valid_o      (ex_valid_o)
  );

  // Jump target to IF
  assign jump_target_o = alu_req_i.operand_c;

endmodule

// File: testbench/ex_stage_tb.sv
// Directed testbench for the execute stage
// Inputs change on the rising edge and outputs are sampled on the falling edge
// Operands come from a 32-bit Fibonacci LFSR with a fixed seed
// The run stops at the first error or when the cycle limit is passed
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_stage_tb;

  import ex_pkg::*;

  localparam int XLEN   = `EX_XLEN;
  localparam int REG_AW = `EX_REG_AW;

  // Test lengths in cycles
  localparam int RESET_CYCLES = 16;
  localparam int ALU_OPS      = 10;
  localparam int ALU_ITERS    = 20;
  localparam int CMP_OPS      = 6;
  localparam int CMP_ITERS    = 10;
  localparam int MUL_ITERS    = 5;
  // Short tests and idle cycles between tests add about 30
  localparam int TEST_CYCLES  = RESET_CYCLES + ALU_OPS * ALU_ITERS + CMP_OPS * CMP_ITERS
                                + MUL_ITERS + 3 * MUL_ITERS * 2 + 30;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + `EX_TIMEOUT_SLACK;

  logic                clk;
  logic                rst_n;
  alu_req_t            alu_req_i;
  mult_req_t           mult_req_i;
  logic                csr_access_i;
  logic [XLEN-1:0]     csr_rdata_i;
  logic                regfile_alu_we_i;
  logic [REG_AW-1:0]   regfile_alu_waddr_i;
  logic                regfile_we_i;
  logic [REG_AW-1:0]   regfile_waddr_i;
  logic                lsu_en_i;
  logic [XLEN-1:0]     lsu_rdata_i;
  logic                lsu_ready_ex_i;
  logic                branch_in_ex_i;
  logic                wb_ready_i;
  wr_port_t            fw_o;
  wr_port_t            wb_o;
  logic [XLEN-1:0]     jump_target_o;
  logic                branch_decision_o;
  logic                mult_multicycle_o;
  logic                ex_ready_o;
  logic                ex_valid_o;

  logic [31:0]         lfsr_state = 32'd74876;
  int                  cycle_count = 0;

  ex_stage uut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req_i),
    .mult_req_i          (mult_req_i),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .wb_ready_i          (wb_ready_i),
    .fw_o                (fw_o),
    .wb_o                (wb_o),
    .jump_target_o       (jump_target_o),
    .branch_decision_o   (branch_decision_o),
    .mult_multicycle_o   (mult_multicycle_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random operands
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1 give a maximal length sequence
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [XLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[XLEN-2:0], lfsr_state[31]};
    end
  endtask

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  function automatic logic [XLEN-1:0] alu_expect(input alu_op_e op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
      default:  return '0;
    endcase
  endfunction

  function automatic logic cmp_expect(input alu_op_e op, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Unsigned product, then the high word corrected for each negative signed operand
  function automatic logic [XLEN-1:0] mult_expect(input mult_op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] p;
    logic [XLEN-1:0]   hi;
    p  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    hi = p[2*XLEN-1:XLEN];
    if (op == MULT_MUL) begin
      return p[XLEN-1:0];
    end
    // A negative operand weighs 2^XLEN less than its unsigned reading
    if ((op == MULT_MULH || op == MULT_MULHSU) && a[XLEN-1]) begin
      hi = hi - b;
    end
    if (op == MULT_MULH && b[XLEN-1]) begin
      hi = hi - a;
    end
    return hi;
  endfunction

  ////////////////////////////////////////
  // Error reporting and compare tasks
  ////////////////////////////////////////

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "run stopped after the first error");
  endtask

  task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_wr(input wr_port_t got, input wr_port_t exp, input string what);
    string line;
    if (got !== exp) begin
      line = $sformatf("mismatch at %0t: %s, got we=%b waddr=%0d wdata=%h", $time, what,
                       got.we, got.waddr, got.wdata);
      line = {line, $sformatf(", expected we=%b waddr=%0d wdata=%h",
                              exp.we, exp.waddr, exp.wdata)};
      fail_run(line);
    end
  endtask

  // Cycle limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  ////////////////////////////////////////
  // Drive helpers
  ////////////////////////////////////////

  task automatic drive_alu(input logic en, input alu_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
    alu_req_t req;
    req.enable    = en;
    req.op        = op;
    req.operand_a = a;
    req.operand_b = b;
    req.operand_c = c;
    alu_req_i <= req;
  endtask

  task automatic drive_mult(input logic en, input mult_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
    mult_req_t req;
    req.enable    = en;
    req.op        = op;
    req.operand_a = a;
    req.operand_b = b;
    mult_req_i <= req;
  endtask

  // Nothing issued, LSU and WB ready
  task automatic clear_inputs;
    drive_alu(1'b0, ALU_ADD, '0, '0, '0);
    drive_mult(1'b0, MULT_MUL, '0, '0);
    csr_access_i        <= 1'b0;
    csr_rdata_i         <= '0;
    regfile_alu_we_i    <= 1'b0;
    regfile_alu_waddr_i <= '0;
    regfile_we_i        <= 1'b0;
    regfile_waddr_i     <= '0;
    lsu_en_i            <= 1'b0;
    lsu_rdata_i         <= '0;
    lsu_ready_ex_i      <= 1'b1;
    branch_in_ex_i      <= 1'b0;
    wb_ready_i          <= 1'b1;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_alu_ops;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    logic [XLEN-1:0] w;
    wr_port_t        exp;
    for (int i = 0; i < ALU_OPS; i++) begin
      op = alu_op_e'(i);
      for (int n = 0; n < ALU_ITERS; n++) begin
        draw_bits(XLEN, a);
        draw_bits(XLEN, b);
        draw_bits(XLEN, c);
        draw_bits(REG_AW, w);
        @(posedge clk);
        drive_alu(1'b1, op, a, b, c);
        regfile_alu_we_i    <= 1'b1;
        regfile_alu_waddr_i <= w[REG_AW-1:0];
        @(negedge clk);
        exp.we    = 1'b1;
        exp.waddr = w[REG_AW-1:0];
        exp.wdata = alu_expect(op, a, b);
        check_wr(fw_o, exp, $sformatf("forward port for %s", op.name()));
      end
    end
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic test_branches;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    for (int i = 0; i < CMP_OPS; i++) begin
      op = alu_op_e'(ALU_OPS + i);
      for (int n = 0; n < CMP_ITERS; n++) begin
        draw_bits(XLEN, a);
        draw_bits(XLEN, b);
        draw_bits(XLEN, c);
        // Every other pair is equal to hit the zero flag
        if (n % 2 == 1) begin
          b = a;
        end
        @(posedge clk);
        drive_alu(1'b1, op, a, b, c);
        branch_in_ex_i <= 1'b1;
        @(negedge clk);
        check_bit(branch_decision_o, cmp_expect(op, a, b),
                  $sformatf("branch decision for %s", op.name()));
        check_word(jump_target_o, c, "jump target");
      end
    end
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic test_multiplier;
    mult_op_e        op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    // Low word in the issue cycle
    for (int n = 0; n < MUL_ITERS; n++) begin
      draw_bits(XLEN, a);
      draw_bits(XLEN, b);
      @(posedge clk);
      drive_mult(1'b1, MULT_MUL, a, b);
      regfile_alu_we_i <= 1'b1;
      @(negedge clk);
      check_word(fw_o.wdata, mult_expect(MULT_MUL, a, b), "MUL low product");
      check_bit(ex_ready_o, 1'b1, "ready during MUL");
    end
    // High word one cycle later
    for (int i = 1; i < 4; i++) begin
      op = mult_op_e'(i);
      for (int n = 0; n < MUL_ITERS; n++) begin
        draw_bits(XLEN, a);
        draw_bits(XLEN, b);
        @(posedge clk);
        drive_mult(1'b1, op, a, b);
        @(negedge clk);
        check_bit(ex_ready_o, 1'b0, $sformatf("ready in first cycle of %s", op.name()));
        check_bit(mult_multicycle_o, 1'b1, $sformatf("multicycle flag of %s", op.name()));
        @(negedge clk);
        check_word(fw_o.wdata, mult_expect(op, a, b), $sformatf("%s high word", op.name()));
        check_bit(ex_valid_o, 1'b1, $sformatf("valid in second cycle of %s", op.name()));
        check_bit(ex_ready_o, 1'b1, $sformatf("ready in second cycle of %s", op.name()));
      end
    end
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic test_result_priority;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    draw_bits(XLEN, a);
    draw_bits(XLEN, b);
    draw_bits(XLEN, r);
    @(posedge clk);
    drive_alu(1'b1, ALU_ADD, a, b, '0);
    drive_mult(1'b1, MULT_MUL, b, a);
    csr_access_i <= 1'b1;
    csr_rdata_i  <= r;
    @(negedge clk);
    check_word(fw_o.wdata, r, "CSR data over ALU and multiplier");
    @(posedge clk);
    csr_access_i <= 1'b0;
    @(negedge clk);
    check_word(fw_o.wdata, mult_expect(MULT_MUL, b, a), "multiplier over ALU");
    @(posedge clk);
    drive_mult(1'b0, MULT_MUL, '0, '0);
    @(negedge clk);
    check_word(fw_o.wdata, alu_expect(ALU_ADD, a, b), "ALU alone");
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic test_load_port;
    logic [XLEN-1:0] w;
    logic [XLEN-1:0] d;
    wr_port_t        exp;
    draw_bits(REG_AW, w);
    draw_bits(XLEN, d);
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= w[REG_AW-1:0];
    lsu_rdata_i     <= d;
    @(negedge clk);
    check_bit(ex_valid_o, 1'b1, "valid for load");
    @(posedge clk);
    lsu_en_i     <= 1'b0;
    regfile_we_i <= 1'b0;
    @(negedge clk);
    exp.we    = 1'b1;
    exp.waddr = w[REG_AW-1:0];
    exp.wdata = d;
    check_wr(wb_o, exp, "load write port");
    // Idle cycle with WB ready flushes the write
    @(negedge clk);
    check_bit(wb_o.we, 1'b0, "load write enable after idle cycle");
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic test_back_pressure;
    logic [XLEN-1:0] w;
    logic [XLEN-1:0] d;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] hi;
    wr_port_t        exp;
    draw_bits(REG_AW, w);
    draw_bits(XLEN, d);
    draw_bits(XLEN, a);
    draw_bits(XLEN, b);
    hi = mult_expect(MULT_MULHU, a, b);
    exp.we    = 1'b1;
    exp.waddr = w[REG_AW-1:0];
    exp.wdata = d;
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= w[REG_AW-1:0];
    lsu_rdata_i     <= d;
    // WB busy while a second load waits in EX
    @(posedge clk);
    wb_ready_i      <= 1'b0;
    regfile_waddr_i <= ~w[REG_AW-1:0];
    for (int n = 0; n < 2; n++) begin
      @(negedge clk);
      check_bit(ex_ready_o, 1'b0, "ready under back-pressure");
      check_bit(ex_valid_o, 1'b0, "valid under back-pressure");
      check_wr(wb_o, exp, "load port held");
    end
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    @(negedge clk);
    check_bit(ex_ready_o, 1'b1, "ready with branch in EX");
    check_bit(ex_valid_o, 1'b0, "valid with branch in EX");
    @(posedge clk);
    branch_in_ex_i <= 1'b0;
    lsu_en_i       <= 1'b0;
    regfile_we_i   <= 1'b0;
    drive_mult(1'b1, MULT_MULHU, a, b);
    @(negedge clk);
    check_bit(mult_multicycle_o, 1'b1, "multicycle flag of stalled MULHU");
    // New operands while stalled must not disturb the captured product
    for (int n = 0; n < 3; n++) begin
      @(posedge clk);
      drive_mult(1'b1, MULT_MULHU, ~a, b ^ a);
      @(negedge clk);
      check_word(fw_o.wdata, hi, "stalled MULHU result");
      check_bit(ex_ready_o, 1'b0, "ready during stalled MULHU");
      check_bit(ex_valid_o, 1'b0, "valid during stalled MULHU");
    end
    check_wr(wb_o, exp, "load port held through multiply stall");
    @(posedge clk);
    wb_ready_i <= 1'b1;
    @(negedge clk);
    check_word(fw_o.wdata, hi, "MULHU result after stall");
    check_bit(ex_ready_o, 1'b1, "ready after stall");
    check_bit(ex_valid_o, 1'b1, "valid after stall");
    @(posedge clk);
    clear_inputs();
    @(negedge clk);
    check_bit(mult_multicycle_o, 1'b0, "multiplier back in idle");
    check_bit(wb_o.we, 1'b0, "load port cleared after stall");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clear_inputs();
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit(ex_ready_o, 1'b1, "ready after reset");
    check_bit(mult_multicycle_o, 1'b0, "multicycle after reset");
    check_bit(wb_o.we, 1'b0, "write-back enable after reset");
    test_alu_ops();
    test_branches();
    test_multiplier();
    test_result_priority();
    test_load_port();
    test_back_pressure();
    $display("TEST OK");
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_fw_mux.sv
rtl/ex_wb_port.sv
rtl/ex_stage.sv
testbench/ex_stage_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := sources.f
TB_TOP     := ex_stage_tb
RTL_TOP    := ex_stage
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
